// ==== all.f ====
+incdir+hdl
hdl/mips_pkg.sv
hdl/pc_redirect_if.sv
hdl/instruction_fetch.sv
hdl/instruction_decode.sv
hdl/execution.sv
hdl/memory_access.sv
hdl/pipeline.sv
verification/pipeline_checker.sv
verification/pipeline_tb.sv

// ==== hdl/execution.sv ====
`timescale 1ns/1ps

module execution import mips_pkg::*; (
	input logic [5:0] funct,
	input alu_op_t alu_op,
	input word_t next_pc,
	input word_t rdata1,
	input word_t rdata2,
	input word_t extended,
	input logic alu_src,
	output word_t alu_out,
	output logic zero,
	output word_t branch_target
);

	alu_ctrl_t alu_ctrl;
	word_t operand_b;

	// ALU control
	always_comb
	begin
		case (alu_op)
			alu_op_sub:
				alu_ctrl = alu_sub;
			alu_op_funct:
			begin
				case (funct)
					funct_sub: alu_ctrl = alu_sub;
					funct_and: alu_ctrl = alu_and;
					funct_or: alu_ctrl = alu_or;
					funct_slt: alu_ctrl = alu_slt;
					funct_add: alu_ctrl = alu_add;
					// nop (sll r0) lands here
					default: alu_ctrl = alu_add;
				endcase
			end
			default:
				alu_ctrl = alu_add;
		endcase
	end

	assign operand_b = alu_src ? extended : rdata2;

	always_comb
	begin
		case (alu_ctrl)
			alu_sub: alu_out = rdata1 - operand_b;
			alu_and: alu_out = rdata1 & operand_b;
			alu_or: alu_out = rdata1 | operand_b;
			alu_slt: alu_out = ($signed(rdata1) < $signed(operand_b)) ? 32'd1 : 32'd0;
			default: alu_out = rdata1 + operand_b;
		endcase
	end

	assign zero = (alu_out == '0);

	// Word offset relative to the delay-free next PC
	assign branch_target = next_pc + {extended[29:0], 2'b00};

endmodule

// ==== hdl/instruction_decode.sv ====
`timescale 1ns/1ps

module instruction_decode import mips_pkg::*; (
	input logic clk,
	input logic reset,
	input word_t instruction,
	input word_t next_pc,
	input logic wb_write,
	input reg_idx_t wb_reg,
	input word_t wb_data,
	output word_t rdata1,
	output word_t rdata2,
	output word_t extended,
	output word_t jump_target,
	output reg_idx_t write_reg,
	output alu_op_t alu_op,
	output logic reg_write,
	output logic mem_read,
	output logic mem_write,
	output logic mem_to_reg,
	output logic alu_src,
	output logic branch,
	output logic jump
);

	opcode_t opcode;
	reg_idx_t rs;
	reg_idx_t rt;
	reg_idx_t rd;
	word_t regs [32];

	assign opcode = opcode_t'(instruction[31:26]);
	assign rs = instruction[25:21];
	assign rt = instruction[20:16];
	assign rd = instruction[15:11];

	//////////////////////////////////////////////////
	// Main control decoder
	//////////////////////////////////////////////////

	always_comb
	begin
		reg_write = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		mem_to_reg = 1'b0;
		alu_src = 1'b0;
		branch = 1'b0;
		jump = 1'b0;
		alu_op = alu_op_add;
		write_reg = rt;
		case (opcode)
			op_rtype:
			begin
				reg_write = 1'b1;
				alu_op = alu_op_funct;
				write_reg = rd;
			end
			op_lw:
			begin
				reg_write = 1'b1;
				mem_read = 1'b1;
				mem_to_reg = 1'b1;
				alu_src = 1'b1;
			end
			op_sw:
			begin
				mem_write = 1'b1;
				alu_src = 1'b1;
			end
			op_beq:
			begin
				branch = 1'b1;
				alu_op = alu_op_sub;
			end
			op_addi:
			begin
				reg_write = 1'b1;
				alu_src = 1'b1;
			end
			op_j:
				jump = 1'b1;
			default:
				reg_write = 1'b0;
		endcase
	end

	assign extended = {{16{instruction[15]}}, instruction[15:0]};
	assign jump_target = {next_pc[31:28], instruction[25:0], 2'b00};

	//////////////////////////////////////////////////
	// Register file
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else if (wb_write && wb_reg != '0)
			regs[wb_reg] <= wb_data;
	end

	// WB result of this cycle is visible to the reads
	always_comb
	begin
		if (wb_write && wb_reg != '0 && wb_reg == rs)
			rdata1 = wb_data;
		else
			rdata1 = regs[rs];
		if (wb_write && wb_reg != '0 && wb_reg == rt)
			rdata2 = wb_data;
		else
			rdata2 = regs[rt];
	end

endmodule

// ==== hdl/instruction_fetch.sv ====
`timescale 1ns/1ps
`include "mips_cfg.svh"

module instruction_fetch import mips_pkg::*; (
	input logic clk,
	input logic reset,
	input logic prog_we,
	input word_t prog_addr,
	input word_t prog_data,
	pc_redirect_if.sink redirect,
	output word_t instruction,
	output word_t next_pc
);

	localparam int prog_aw = $clog2(`MIPS_PROG_WORDS);

	word_t pc;
	word_t pc_target;
	word_t prog_mem [`MIPS_PROG_WORDS];

	assign next_pc = pc + 32'd4;

	// Jump takes priority over a taken branch
	always_comb
	begin
		if (redirect.jump)
			pc_target = redirect.jump_target;
		else if (redirect.take)
			pc_target = redirect.branch_target;
		else
			pc_target = next_pc;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			pc <= `MIPS_RESET_PC;
		else
			pc <= pc_target;
	end

	// Load port uses byte addresses like the PC
	always_ff @(posedge clk)
	begin
		if (prog_we)
			prog_mem[prog_addr[prog_aw+1:2]] <= prog_data;
	end

	assign instruction = prog_mem[pc[prog_aw+1:2]];

endmodule

// ==== hdl/memory_access.sv ====
`timescale 1ns/1ps
`include "mips_cfg.svh"

module memory_access import mips_pkg::*; (
	input logic clk,
	input logic valid,
	input logic branch,
	input logic zero,
	input logic mem_read,
	input logic mem_write,
	input word_t address,
	input word_t write_data,
	output word_t read_data,
	pc_redirect_if.source redirect
);

	localparam int data_aw = $clog2(`MIPS_DATA_WORDS);

	word_t data_mem [`MIPS_DATA_WORDS];
	logic [data_aw-1:0] word_idx;

	assign word_idx = address[data_aw+1:2];

	always_ff @(posedge clk)
	begin
		if (valid && mem_write)
			data_mem[word_idx] <= write_data;
	end

	assign read_data = mem_read ? data_mem[word_idx] : '0;

	// beq resolved here one stage after the compare
	assign redirect.take = valid & branch & zero;

endmodule

// ==== hdl/mips_cfg.svh ====
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// Program memory depth in 32-bit words
`define MIPS_PROG_WORDS 64

// Data memory depth in 32-bit words
`define MIPS_DATA_WORDS 64

// First fetch address after reset
`define MIPS_RESET_PC 32'h0000_0000

`endif

// ==== hdl/mips_pkg.sv ====
package mips_pkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [1:0] alu_op_t;

	// ALUOp from the main decoder
	localparam alu_op_t alu_op_add = 2'b00;
	localparam alu_op_t alu_op_sub = 2'b01;
	localparam alu_op_t alu_op_funct = 2'b10;

	// R-type function field
	localparam logic [5:0] funct_add = 6'h20;
	localparam logic [5:0] funct_sub = 6'h22;
	localparam logic [5:0] funct_and = 6'h24;
	localparam logic [5:0] funct_or = 6'h25;
	localparam logic [5:0] funct_slt = 6'h2a;

	typedef enum logic [2:0] {alu_add, alu_sub, alu_and, alu_or, alu_slt} alu_ctrl_t;

	typedef enum logic [5:0] {
		op_rtype = 6'h00,
		op_j = 6'h02,
		op_beq = 6'h04,
		op_addi = 6'h08,
		op_lw = 6'h23,
		op_sw = 6'h2b
	} opcode_t;

endpackage

// ==== hdl/pc_redirect_if.sv ====
`timescale 1ns/1ps

// Branch and jump redirect from the MA stage back to fetch
interface pc_redirect_if import mips_pkg::*; ();

	logic take;
	logic jump;
	word_t branch_target;
	word_t jump_target;

	modport source (output take, output jump, output branch_target, output jump_target);

	modport sink (input take, input jump, input branch_target, input jump_target);

endinterface

// ==== hdl/pipeline.sv ====
`timescale 1ns/1ps

module pipeline import mips_pkg::*; (
	input logic clk,
	input logic reset,
	input logic prog_we,
	input word_t prog_addr,
	input word_t prog_data,
	output logic retire_valid,
	output reg_idx_t retire_reg,
	output word_t retire_data
);

	pc_redirect_if redirect ();

	logic flush;

	// IF
	word_t if_instruction, if_next_pc;

	// ID
	logic id_valid;
	word_t id_instruction, id_next_pc;
	word_t id_rdata1, id_rdata2, id_extended, id_jump_target;
	reg_idx_t id_write_reg;
	alu_op_t id_alu_op;
	logic id_reg_write, id_mem_read, id_mem_write, id_mem_to_reg;
	logic id_alu_src, id_branch, id_jump;

	// EX
	logic ex_valid;
	logic [5:0] ex_funct;
	word_t ex_next_pc, ex_rdata1, ex_rdata2, ex_extended, ex_jump_target;
	reg_idx_t ex_write_reg;
	alu_op_t ex_alu_op;
	logic ex_reg_write, ex_mem_read, ex_mem_write, ex_mem_to_reg;
	logic ex_alu_src, ex_branch, ex_jump;
	word_t ex_alu_out, ex_branch_target;
	logic ex_zero;

	// MA
	logic ma_valid;
	word_t ma_alu_out, ma_write_data, ma_branch_target, ma_jump_target, ma_read_data;
	reg_idx_t ma_write_reg;
	logic ma_zero, ma_branch, ma_jump, ma_mem_read, ma_mem_write;
	logic ma_mem_to_reg, ma_reg_write;

	// WB
	logic wb_valid;
	word_t wb_alu_out, wb_mem_data;
	reg_idx_t wb_write_reg;
	logic wb_mem_to_reg, wb_reg_write;

	//////////////////////////////////////////////////
	// Redirect and stage valid bits
	//////////////////////////////////////////////////

	assign redirect.jump = ma_valid & ma_jump;
	assign redirect.branch_target = ma_branch_target;
	assign redirect.jump_target = ma_jump_target;
	assign flush = redirect.take | redirect.jump;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			id_valid <= 1'b0;
			ex_valid <= 1'b0;
			ma_valid <= 1'b0;
			wb_valid <= 1'b0;
		end
		else
		begin
			id_valid <= ~flush;
			ex_valid <= id_valid & ~flush;
			ma_valid <= ex_valid & ~flush;
			wb_valid <= ma_valid;
		end
	end

	//////////////////////////////////////////////////
	// Stage payload registers
	//////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		// IF/ID
		id_instruction <= if_instruction;
		id_next_pc <= if_next_pc;
		// ID/EX
		ex_funct <= id_instruction[5:0];
		ex_next_pc <= id_next_pc;
		ex_rdata1 <= id_rdata1;
		ex_rdata2 <= id_rdata2;
		ex_extended <= id_extended;
		ex_jump_target <= id_jump_target;
		ex_write_reg <= id_write_reg;
		ex_alu_op <= id_alu_op;
		ex_reg_write <= id_reg_write;
		ex_mem_read <= id_mem_read;
		ex_mem_write <= id_mem_write;
		ex_mem_to_reg <= id_mem_to_reg;
		ex_alu_src <= id_alu_src;
		ex_branch <= id_branch;
		ex_jump <= id_jump;
		// EX/MA
		ma_alu_out <= ex_alu_out;
		ma_write_data <= ex_rdata2;
		ma_branch_target <= ex_branch_target;
		ma_jump_target <= ex_jump_target;
		ma_write_reg <= ex_write_reg;
		ma_zero <= ex_zero;
		ma_branch <= ex_branch;
		ma_jump <= ex_jump;
		ma_mem_read <= ex_mem_read;
		ma_mem_write <= ex_mem_write;
		ma_mem_to_reg <= ex_mem_to_reg;
		ma_reg_write <= ex_reg_write;
		// MA/WB
		wb_alu_out <= ma_alu_out;
		wb_mem_data <= ma_read_data;
		wb_write_reg <= ma_write_reg;
		wb_mem_to_reg <= ma_mem_to_reg;
		wb_reg_write <= ma_reg_write;
	end

	//////////////////////////////////////////////////
	// Write-back and retirement
	//////////////////////////////////////////////////

	assign retire_data = wb_mem_to_reg ? wb_mem_data : wb_alu_out;
	assign retire_reg = wb_write_reg;
	// Writes to r0 are dropped here
	assign retire_valid = wb_valid & wb_reg_write & (wb_write_reg != '0);

	instruction_fetch u_fetch (
		.clk(clk),
		.reset(reset),
		.prog_we(prog_we),
		.prog_addr(prog_addr),
		.prog_data(prog_data),
		.redirect(redirect.sink),
		.instruction(if_instruction),
		.next_pc(if_next_pc)
	);

	instruction_decode u_decode (
		.clk(clk),
		.reset(reset),
		.instruction(id_instruction),
		.next_pc(id_next_pc),
		.wb_write(retire_valid),
		.wb_reg(wb_write_reg),
		.wb_data(retire_data),
		.rdata1(id_rdata1),
		.rdata2(id_rdata2),
		.extended(id_extended),
		.jump_target(id_jump_target),
		.write_reg(id_write_reg),
		.alu_op(id_alu_op),
		.reg_write(id_reg_write),
		.mem_read(id_mem_read),
		.mem_write(id_mem_write),
		.mem_to_reg(id_mem_to_reg),
		.alu_src(id_alu_src),
		.branch(id_branch),
		.jump(id_jump)
	);

	execution u_execute (
		.funct(ex_funct),
		.alu_op(ex_alu_op),
		.next_pc(ex_next_pc),
		.rdata1(ex_rdata1),
		.rdata2(ex_rdata2),
		.extended(ex_extended),
		.alu_src(ex_alu_src),
		.alu_out(ex_alu_out),
		.zero(ex_zero),
		.branch_target(ex_branch_target)
	);

	// ALU result is the data address
	memory_access u_memory (
		.clk(clk),
		.valid(ma_valid),
		.branch(ma_branch),
		.zero(ma_zero),
		.mem_read(ma_mem_read),
		.mem_write(ma_mem_write),
		.address(ma_alu_out),
		.write_data(ma_write_data),
		.read_data(ma_read_data),
		.redirect(redirect.source)
	);

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module pipeline_tb \
	--Mdir obj_dir -o sim_pipeline
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

sim_output=$(./obj_dir/sim_pipeline 2>&1)
sim_status=$?
echo "$sim_output"

if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if echo "$sim_output" | grep -qx "All checks passed"; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi

// ==== verification/pipeline_checker.sv ====
`timescale 1ns/1ps
`include "mips_cfg.svh"

module pipeline_checker import mips_pkg::*; (
	input logic clk,
	input logic reset,
	input logic retire_valid,
	input reg_idx_t retire_reg,
	input logic flush,
	input logic ma_valid,
	input word_t if_next_pc
);

	int failure_count = 0;

	// Nothing retires in the first cycle out of reset
	retire_idle_after_reset: assert property (@(posedge clk) reset |=> !retire_valid)
		else
		begin
			failure_count++;
			$error("retire_valid high in the cycle after reset");
		end

	// r0 writes are dropped before the retirement port
	retire_never_r0: assert property (@(posedge clk) disable iff (reset)
		retire_valid |-> (retire_reg != '0))
		else
		begin
			failure_count++;
			$error("retirement reported for register zero");
		end

	// Redirect clears the EX/MA valid bit on the same edge
	flush_clears_ma: assert property (@(posedge clk) disable iff (reset)
		flush |=> !ma_valid)
		else
		begin
			failure_count++;
			$error("EX/MA valid still set after a redirect");
		end

	// PC is next_pc minus four
	pc_at_reset_value: assert property (@(posedge clk)
		reset |=> (if_next_pc == `MIPS_RESET_PC + 32'd4))
		else
		begin
			failure_count++;
			$error("PC not at its reset value after reset");
		end

endmodule

bind pipeline pipeline_checker i_checker (
	.clk(clk),
	.reset(reset),
	.retire_valid(retire_valid),
	.retire_reg(retire_reg),
	.flush(flush),
	.ma_valid(ma_valid),
	.if_next_pc(if_next_pc)
);

// ==== verification/pipeline_patterns.txt ====
# Each line is a tag with up to two hex fields
# test <name> / prog <byte address> <word> / ret <register> <data> / end
test arith
prog 00 2001000c
prog 04 2002000a
prog 08 20000007
prog 0c 00000000
prog 10 00221820
prog 14 00222022
prog 18 00222824
prog 1c 00223025
prog 20 0041382a
prog 24 0022402a
prog 28 2009fffd
prog 2c 00000000
prog 30 00000000
prog 34 0120502a
prog 38 0800000e
ret 01 0000000c
ret 02 0000000a
ret 03 00000016
ret 04 00000002
ret 05 00000008
ret 06 0000000e
ret 07 00000001
ret 08 00000000
ret 09 fffffffd
ret 0a 00000001
test memory
prog 00 20011234
prog 04 20020008
prog 08 00000000
prog 0c 00000000
prog 10 ac410004
prog 14 8c430004
prog 18 00000000
prog 1c 00000000
prog 20 00612020
prog 24 08000009
ret 01 00001234
ret 02 00000008
ret 03 00001234
ret 04 00002468
test branch
prog 00 20010005
prog 04 20020005
prog 08 00000000
prog 0c 00000000
prog 10 10220004
prog 14 20030001
prog 18 20040002
prog 1c 20050003
prog 20 20060004
prog 24 10200004
prog 28 20070007
prog 2c 08000010
prog 30 20080008
prog 34 20090009
prog 38 200a000a
prog 3c 200b000b
prog 40 200c000c
prog 44 08000011
ret 01 00000005
ret 02 00000005
ret 07 00000007
ret 0c 0000000c
end

// ==== verification/pipeline_tb.sv ====
`timescale 1ns/1ps
`include "mips_cfg.svh"

module pipeline_tb import mips_pkg::*; ();

	localparam logic [31:0] tag_test = 32'("test");
	localparam logic [31:0] tag_prog = 32'("prog");
	localparam logic [31:0] tag_ret = 32'("ret");
	localparam logic [31:0] tag_end = 32'("end");
	localparam logic [31:0] tag_comment = 32'("#");

	logic clk;
	logic reset;
	logic prog_we;
	word_t prog_addr;
	word_t prog_data;
	logic retire_valid;
	reg_idx_t retire_reg;
	word_t retire_data;

	int fd;
	int tests_run;
	logic [31:0] tag;
	logic [127:0] test_name;
	word_t load_addr_q[$];
	word_t load_data_q[$];
	reg_idx_t want_reg_q[$];
	word_t want_data_q[$];

	pipeline i_dut (
		.clk(clk),
		.reset(reset),
		.prog_we(prog_we),
		.prog_addr(prog_addr),
		.prog_data(prog_data),
		.retire_valid(retire_valid),
		.retire_reg(retire_reg),
		.retire_data(retire_data)
	);

	always #10 clk = ~clk;

	task automatic abort_run();
		$display("Checks failed");
		$fatal(1);
	endtask

	// Inputs change 2 ns after the rising edge
	task automatic next_cycle();
		@(posedge clk);
		#2;
	endtask

	task automatic compare_reg(input int index, input reg_idx_t expected, input reg_idx_t actual);
		if (actual !== expected)
		begin
			$display("Error: test %0s retirement %0d register expected %0d actual %0d",
				test_name, index, expected, actual);
			abort_run();
		end
	endtask

	task automatic compare_data(input int index, input word_t expected, input word_t actual);
		if (actual !== expected)
		begin
			$display("Error: test %0s retirement %0d data expected %h actual %h",
				test_name, index, expected, actual);
			abort_run();
		end
	endtask

	//////////////////////////////////////////////////
	// Pattern file
	//////////////////////////////////////////////////

	// Next tag token with comment lines skipped
	task automatic read_tag();
		int code;
		logic [8*128-1:0] rest;
		code = $fscanf(fd, "%s", tag);
		while (code == 1 && tag == tag_comment)
		begin
			code = $fgets(rest, fd);
			code = $fscanf(fd, "%s", tag);
		end
		if (code != 1)
		begin
			$display("Pattern file ended without an end marker");
			abort_run();
		end
	endtask

	task automatic read_test();
		int code;
		word_t addr;
		word_t data;
		reg_idx_t rnum;
		load_addr_q.delete();
		load_data_q.delete();
		want_reg_q.delete();
		want_data_q.delete();
		code = $fscanf(fd, "%s", test_name);
		read_tag();
		while (tag == tag_prog || tag == tag_ret)
		begin
			if (tag == tag_prog)
			begin
				code = $fscanf(fd, "%h %h", addr, data);
				if (code != 2 || addr >= 4 * `MIPS_PROG_WORDS)
				begin
					$display("Bad program line in test %0s", test_name);
					abort_run();
				end
				load_addr_q.push_back(addr);
				load_data_q.push_back(data);
			end
			else
			begin
				code = $fscanf(fd, "%h %h", rnum, data);
				if (code != 2)
				begin
					$display("Bad retirement line in test %0s", test_name);
					abort_run();
				end
				want_reg_q.push_back(rnum);
				want_data_q.push_back(data);
			end
			read_tag();
		end
	endtask

	//////////////////////////////////////////////////
	// Load and run one program
	//////////////////////////////////////////////////

	task automatic run_test();
		int seen;
		int idle;
		int cycles;
		int limit;
		next_cycle();
		reset = 1'b1;
		for (int i = 0; i < load_addr_q.size(); i++)
		begin
			prog_we = 1'b1;
			prog_addr = load_addr_q[i];
			prog_data = load_data_q[i];
			next_cycle();
		end
		prog_we = 1'b0;
		repeat (5) next_cycle();
		reset = 1'b0;
		seen = 0;
		idle = 0;
		cycles = 0;
		limit = 20 * load_addr_q.size() + 100;
		// Retirements sampled mid-cycle until 20 quiet cycles follow the last one
		while (seen < want_reg_q.size() || idle < 20)
		begin
			@(negedge clk);
			cycles++;
			if (cycles > limit)
			begin
				$display("Timeout in test %0s after %0d cycles", test_name, cycles);
				abort_run();
			end
			else if (retire_valid)
			begin
				if (seen == want_reg_q.size())
				begin
					$display("Test %0s retired r%0d after its last expected result",
						test_name, retire_reg);
					abort_run();
				end
				else
				begin
					compare_reg(seen, want_reg_q[seen], retire_reg);
					compare_data(seen, want_data_q[seen], retire_data);
					seen++;
				end
			end
			else if (seen == want_reg_q.size())
				idle++;
		end
	endtask

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		prog_we = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		tests_run = 0;
		fd = $fopen("verification/pipeline_patterns.txt", "r");
		if (fd == 0)
		begin
			$display("Cannot open the pattern file");
			abort_run();
		end
		read_tag();
		while (tag == tag_test)
		begin
			read_test();
			run_test();
			tests_run++;
		end
		$fclose(fd);
		if (tag != tag_end)
		begin
			$display("Unknown record in the pattern file");
			abort_run();
		end
		else if (tests_run == 0)
		begin
			$display("Pattern file holds no tests");
			abort_run();
		end
		else if (i_dut.i_checker.failure_count != 0)
		begin
			$display("Checker assertions failed during the run");
			abort_run();
		end
		else
		begin
			$display("All checks passed");
			$finish;
		end
	end

endmodule
